//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = riscv_core_tb
FLIST      = riscv_core.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/riscv_core_tb.sv
// Core testbench: program ROM, ISA reference model and writeback trace checker
module riscv_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import riscv_core_isa_pkg::*;

    localparam int     CLK_PERIOD   = 100;
    localparam int     RESET_CYCLES = 10;
    localparam int     DRAIN_CYCLES = 20;
    localparam int     ROM_AW       = 6;
    localparam int     ROM_WORDS    = 1 << ROM_AW;
    localparam xword_t ROM_BYTES    = 64'(ROM_WORDS * 4);
    localparam int     MODEL_STEPS  = 1000;
    localparam int     RAND_LEN     = 40;

    logic     clk   = 1'b0;
    logic     rst_n = 1'b0;
    xword_t   imem_addr;
    instr_t   imem_instr;
    logic     wb_valid;
    reg_idx_t wb_rd;
    xword_t   wb_data;

    instr_t   rom [ROM_WORDS];
    instr_t   prog [$];
    reg_idx_t exp_rd [$];
    xword_t   exp_data [$];

    integer seed         = 32'hd1fa_a5b9;
    time    deadline     = 64'd1_000_000;
    logic   test_active  = 1'b0;
    int     test_num     = 0;
    int     checked      = 0;
    int     errors       = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;

    riscv_core #(
        .DMEM_WORDS (256)
    ) dut_i (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .o_imem_addr  (imem_addr),
        .i_imem_instr (imem_instr),
        .o_wb_valid   (wb_valid),
        .o_wb_rd      (wb_rd),
        .o_wb_data    (wb_data)
    );

    always
    begin
        #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Fetches past the ROM see bubbles
    assign imem_instr = (imem_addr < ROM_BYTES) ? rom[imem_addr[ROM_AW+1:2]] : '0;

    function automatic void emit(input instr_t w);
        prog.push_back(w);
    endfunction

    function automatic int rand_imm();
        return $random(seed) % 2048;
    endfunction

    // Small register pool so random code is dense with hazards
    function automatic int rand_reg();
        return $unsigned($random(seed)) % 5;
    endfunction

    function automatic instr_t alu_rr(input funct7_t f7, input funct3_t f3,
                                      input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
    endfunction

    function automatic instr_t addi(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), F3_ADDI, 5'(rd), OPC_OP_IMM};
    endfunction

    function automatic instr_t ld(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), F3_LD, 5'(rd), OPC_LOAD};
    endfunction

    function automatic instr_t sd(input int rs2, input int rs1, input int imm);
        logic [11:0] i12;
        i12 = 12'(imm);
        return {i12[11:5], 5'(rs2), 5'(rs1), F3_SD, i12[4:0], OPC_STORE};
    endfunction

    function automatic instr_t beq(input int rs1, input int rs2, input int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), F3_BEQ, o[4:1], o[11], OPC_BRANCH};
    endfunction

    // ISA model: runs the ROM until the self-branch and lists the register writes
    function automatic void run_model();
        xword_t rf [32];
        xword_t dm [256];
        xword_t a;
        xword_t b;
        xword_t v;
        xword_t ea;
        xword_t pc;
        xword_t pc_next;
        xword_t imm_i;
        xword_t imm_s;
        xword_t imm_b;
        instr_t w;
        logic   wr;
        logic   done;
        int     steps;
        exp_rd.delete();
        exp_data.delete();
        for (int i = 0; i < 32; i++)
        begin
            rf[i] = '0;
        end
        for (int i = 0; i < 256; i++)
        begin
            dm[i] = '0;
        end
        pc = '0;
        done = 1'b0;
        steps = 0;
        while (!done && (steps < MODEL_STEPS) && (pc < ROM_BYTES))
        begin
            w = rom[pc[ROM_AW+1:2]];
            a = rf[w[19:15]];
            b = rf[w[24:20]];
            imm_i = {{52{w[31]}}, w[31:20]};
            imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            wr = 1'b1;
            v = '0;
            pc_next = pc + 64'd4;
            case (w[6:0])
                OPC_OP:
                begin
                    case (w[14:12])
                        F3_ADD_SUB: v = (w[31:25] == F7_SUB) ? a - b : a + b;
                        F3_AND:     v = a & b;
                        F3_OR:      v = a | b;
                        F3_XOR:     v = a ^ b;
                        F3_SLT:     v = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                        default:    wr = 1'b0;
                    endcase
                end
                OPC_OP_IMM:
                begin
                    v = a + imm_i;
                end
                OPC_LOAD:
                begin
                    ea = a + imm_i;
                    v = dm[ea[10:3]];
                end
                OPC_STORE:
                begin
                    ea = a + imm_s;
                    dm[ea[10:3]] = b;
                    wr = 1'b0;
                end
                OPC_BRANCH:
                begin
                    wr = 1'b0;
                    if (a == b)
                    begin
                        // Taken branch to itself ends the program
                        done = (imm_b == '0);
                        pc_next = pc + imm_b;
                    end
                end
                default:
                begin
                    wr = 1'b0;
                end
            endcase
            if (wr && (w[11:7] != '0))
            begin
                rf[w[11:7]] = v;
                exp_rd.push_back(w[11:7]);
                exp_data.push_back(v);
            end
            pc = pc_next;
            steps++;
        end
    endfunction

    task automatic check_value(input string name, input xword_t got, input xword_t exp);
        if (got !== exp)
        begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // Sampled mid-cycle where the trace is settled
    always @(negedge clk)
    begin : compare_proc
        reg_idx_t rd_e;
        xword_t   data_e;
        if (test_active && wb_valid)
        begin
            if (exp_rd.size() == 0)
            begin
                $display("Test %0d: extra writeback to x%0d after the expected sequence ended",
                         test_num, wb_rd);
                errors++;
            end
            else
            begin
                rd_e = exp_rd.pop_front();
                data_e = exp_data.pop_front();
                check_value("o_wb_rd", xword_t'(wb_rd), xword_t'(rd_e));
                check_value("o_wb_data", wb_data, data_e);
                checked++;
            end
        end
    end

    initial
    begin : watchdog_proc
        do
        begin
            @(posedge clk);
        end
        while ($time < deadline);
        $display("Timeout: test %0d did not finish its writebacks in time", test_num);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic run_test(input string name);
        int errors_before;
        int cycles;
        test_num++;
        emit(beq(0, 0, 0));
        @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        for (int i = 0; i < ROM_WORDS; i++)
        begin
            rom[i] = (i < prog.size()) ? prog[i] : '0;
        end
        run_model();
        checked = 0;
        errors_before = errors;
        cycles = 8 * prog.size() + RESET_CYCLES + DRAIN_CYCLES;
        deadline = $time + time'(cycles * CLK_PERIOD);
        test_active = 1'b1;
        repeat (RESET_CYCLES)
        begin
            @(posedge clk);
        end
        rst_n <= 1'b1;
        while (exp_rd.size() > 0)
        begin
            @(negedge clk);
        end
        // Room for any stray writeback to show up
        repeat (DRAIN_CYCLES)
        begin
            @(negedge clk);
        end
        test_active = 1'b0;
        if (errors == errors_before)
        begin
            tests_passed++;
        end
        else
        begin
            tests_failed++;
        end
        $display("Test %0d %s: %0d writebacks checked, %0d errors", test_num, name,
                 checked, errors - errors_before);
    endtask

    function automatic void build_random();
        int kind;
        int off;
        funct3_t f3_tab [6];
        f3_tab = '{F3_ADD_SUB, F3_ADD_SUB, F3_AND, F3_OR, F3_XOR, F3_SLT};
        prog.delete();
        for (int s = 0; s < 4; s++)
        begin
            emit(sd(0, 0, s * 8));
        end
        for (int i = 0; i < RAND_LEN; i++)
        begin
            kind = $unsigned($random(seed)) % 10;
            case (kind)
                0, 1, 2, 3, 4, 5:
                begin
                    emit(alu_rr((kind == 1) ? F7_SUB : F7_BASE, f3_tab[kind],
                                rand_reg(), rand_reg(), rand_reg()));
                end
                6: emit(addi(rand_reg(), rand_reg(), rand_imm()));
                7: emit(sd(rand_reg(), 0, 8 * ($unsigned($random(seed)) % 4)));
                8: emit(ld(rand_reg(), 0, 8 * ($unsigned($random(seed)) % 4)));
                default:
                begin
                    // Forward only, never past the final self-branch
                    off = 2 + ($unsigned($random(seed)) % 2);
                    if (prog.size() + off > 4 + RAND_LEN)
                    begin
                        off = 4 + RAND_LEN - prog.size();
                    end
                    emit(beq(rand_reg(), rand_reg(), off * 4));
                end
            endcase
        end
    endfunction

    initial
    begin : sequence_proc
        prog.delete();
        emit(addi(1, 0, -5));
        emit(addi(2, 0, rand_imm()));
        emit(addi(3, 0, rand_imm()));
        emit(addi(4, 0, -300));
        emit(alu_rr(F7_BASE, F3_ADD_SUB, 5, 1, 3));
        emit(alu_rr(F7_SUB, F3_ADD_SUB, 6, 4, 2));
        emit(alu_rr(F7_BASE, F3_AND, 7, 1, 2));
        emit(alu_rr(F7_BASE, F3_OR, 8, 3, 4));
        emit(alu_rr(F7_BASE, F3_XOR, 9, 2, 4));
        emit(alu_rr(F7_BASE, F3_SLT, 10, 4, 1));
        emit(alu_rr(F7_BASE, F3_SLT, 11, 1, 4));
        // Mixed signs tell a signed compare from an unsigned one
        emit(alu_rr(F7_BASE, F3_SLT, 12, 1, 0));
        run_test("independent ALU");

        // MEM and WB forwarding on both operands
        prog.delete();
        emit(addi(1, 0, rand_imm()));
        emit(alu_rr(F7_BASE, F3_ADD_SUB, 2, 1, 1));
        emit(alu_rr(F7_BASE, F3_ADD_SUB, 3, 2, 1));
        emit(alu_rr(F7_SUB, F3_ADD_SUB, 4, 3, 2));
        emit(alu_rr(F7_BASE, F3_XOR, 5, 1, 2));
        emit(alu_rr(F7_BASE, F3_AND, 6, 4, 4));
        emit(alu_rr(F7_BASE, F3_SLT, 7, 6, 5));
        emit(alu_rr(F7_BASE, F3_OR, 8, 7, 6));
        run_test("forwarding");

        prog.delete();
        emit(addi(1, 0, rand_imm()));
        emit(addi(2, 0, rand_imm()));
        emit(sd(1, 0, 16));
        emit(sd(2, 0, 24));
        emit(ld(3, 0, 16));
        emit(alu_rr(F7_BASE, F3_ADD_SUB, 4, 3, 2));
        emit(ld(5, 0, 24));
        emit(alu_rr(F7_BASE, F3_ADD_SUB, 6, 5, 5));
        emit(ld(7, 0, 16));
        emit(sd(7, 0, 32));
        emit(ld(8, 0, 32));
        emit(addi(9, 8, 1));
        run_test("store, load and load-use");

        prog.delete();
        emit(addi(1, 0, 7));
        emit(addi(2, 0, 7));
        emit(beq(1, 2, 12));
        emit(addi(3, 0, 1));
        emit(addi(4, 0, 2));
        emit(addi(5, 0, 3));
        emit(beq(1, 5, 8));
        emit(addi(6, 0, 4));
        emit(addi(7, 0, 9));
        emit(beq(7, 7, 8));
        emit(addi(8, 0, 5));
        emit(addi(9, 7, 6));
        run_test("branches");

        // Nonzero results aimed at x0 so a forwarded x0 would show
        prog.delete();
        emit(addi(0, 0, 5));
        emit(addi(1, 0, 3));
        emit(sd(1, 0, 0));
        emit(ld(0, 0, 0));
        emit(alu_rr(F7_BASE, F3_ADD_SUB, 2, 0, 1));
        emit(alu_rr(F7_BASE, F3_ADD_SUB, 0, 1, 1));
        emit(alu_rr(F7_BASE, F3_OR, 3, 0, 1));
        emit(alu_rr(F7_BASE, F3_OR, 4, 0, 0));
        run_test("x0 writes");

        build_random();
        run_test("random program");

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if ((tests_failed == 0) && (errors == 0))
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- hdl/riscv_core.sv
// RV64I subset core: five-stage pipeline with PC, stage registers, forwarding and writeback trace
module riscv_core
#(
    parameter riscv_core_isa_pkg::xword_t RESET_PC   = '0,
    parameter int                         DMEM_WORDS = 256
)
(
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    output riscv_core_isa_pkg::xword_t   o_imem_addr,
    input  riscv_core_isa_pkg::instr_t   i_imem_instr,
    output logic                         o_wb_valid,
    output riscv_core_isa_pkg::reg_idx_t o_wb_rd,
    output riscv_core_isa_pkg::xword_t   o_wb_data
);

    import riscv_core_isa_pkg::*;
    import riscv_core_ctrl_pkg::*;

    // Fetch
    xword_t   pc_q;
    xword_t   pc_next;

    // Decode
    instr_t   instr_id;
    xword_t   pc_id;
    reg_idx_t rs1_id;
    reg_idx_t rs2_id;
    reg_idx_t rd_id;
    xword_t   imm_id;
    alu_op_e  alu_op_id;
    logic     alu_src_imm_id;
    logic     regwrite_id;
    logic     mem_read_id;
    logic     mem_write_id;
    logic     branch_id;
    xword_t   rdata1_id;
    xword_t   rdata2_id;

    // Execute
    xword_t   pc_ex;
    reg_idx_t rs1_ex;
    reg_idx_t rs2_ex;
    reg_idx_t rd_ex;
    xword_t   imm_ex;
    xword_t   rdata1_ex;
    xword_t   rdata2_ex;
    alu_op_e  alu_op_ex;
    logic     alu_src_imm_ex;
    logic     regwrite_ex;
    res_src_e res_src_ex;
    logic     mem_write_ex;
    logic     branch_ex;
    fwd_sel_e forwarda_ex;
    fwd_sel_e forwardb_ex;
    xword_t   src_a_ex;
    xword_t   store_data_ex;
    xword_t   alu_result_ex;
    logic     alu_zero_ex;
    logic     pcsrc_ex;

    // Memory
    xword_t   alu_result_mem;
    xword_t   store_data_mem;
    xword_t   load_data_mem;
    reg_idx_t rd_mem;
    logic     regwrite_mem;
    res_src_e res_src_mem;
    logic     mem_write_mem;

    // Writeback
    xword_t   alu_result_wb;
    xword_t   load_data_wb;
    xword_t   result_wb;
    reg_idx_t rd_wb;
    logic     regwrite_wb;
    res_src_e res_src_wb;

    logic stall_if;
    logic stall_id;
    logic flush_id;
    logic flush_ex;

    // Branch target wins over a stall
    always_comb
    begin : next_pc_proc
        if (pcsrc_ex)
        begin
            pc_next = pc_ex + imm_ex;
        end
        else if (stall_if)
        begin
            pc_next = pc_q;
        end
        else
        begin
            pc_next = pc_q + 64'd4;
        end
    end

    // Control state; every stage is a bubble after reset
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin : ctrl_regs_proc
        if (!i_rst_n)
        begin
            pc_q          <= RESET_PC;
            instr_id      <= '0;
            regwrite_ex   <= 1'b0;
            res_src_ex    <= RES_ALU;
            mem_write_ex  <= 1'b0;
            branch_ex     <= 1'b0;
            regwrite_mem  <= 1'b0;
            res_src_mem   <= RES_ALU;
            mem_write_mem <= 1'b0;
            regwrite_wb   <= 1'b0;
            res_src_wb    <= RES_ALU;
        end
        else
        begin
            pc_q <= pc_next;
            if (flush_id)
            begin
                instr_id <= '0;
            end
            else if (!stall_id)
            begin
                instr_id <= i_imem_instr;
            end
            regwrite_ex   <= regwrite_id && !flush_ex;
            res_src_ex    <= (mem_read_id && !flush_ex) ? RES_MEM : RES_ALU;
            mem_write_ex  <= mem_write_id && !flush_ex;
            branch_ex     <= branch_id && !flush_ex;
            regwrite_mem  <= regwrite_ex;
            res_src_mem   <= res_src_ex;
            mem_write_mem <= mem_write_ex;
            regwrite_wb   <= regwrite_mem;
            res_src_wb    <= res_src_mem;
        end
    end

    // Datapath payload follows the control bits
    always_ff @(posedge i_clk)
    begin : data_regs_proc
        if (!stall_id)
        begin
            pc_id <= pc_q;
        end
        pc_ex          <= pc_id;
        rs1_ex         <= rs1_id;
        rs2_ex         <= rs2_id;
        rd_ex          <= rd_id;
        imm_ex         <= imm_id;
        rdata1_ex      <= rdata1_id;
        rdata2_ex      <= rdata2_id;
        alu_op_ex      <= alu_op_id;
        alu_src_imm_ex <= alu_src_imm_id;
        alu_result_mem <= alu_result_ex;
        store_data_mem <= store_data_ex;
        rd_mem         <= rd_ex;
        alu_result_wb  <= alu_result_mem;
        load_data_wb   <= load_data_mem;
        rd_wb          <= rd_mem;
    end

    riscv_core_decoder decoder_i
    (
        .i_instr       (instr_id),
        .o_rs1         (rs1_id),
        .o_rs2         (rs2_id),
        .o_rd          (rd_id),
        .o_imm         (imm_id),
        .o_alu_op      (alu_op_id),
        .o_alu_src_imm (alu_src_imm_id),
        .o_regwrite    (regwrite_id),
        .o_mem_read    (mem_read_id),
        .o_mem_write   (mem_write_id),
        .o_branch      (branch_id)
    );

    riscv_core_regfile regfile_i
    (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_rs1    (rs1_id),
        .i_rs2    (rs2_id),
        .i_rd     (rd_wb),
        .i_we     (regwrite_wb),
        .i_wdata  (result_wb),
        .o_rdata1 (rdata1_id),
        .o_rdata2 (rdata2_id)
    );

    // Operand selection from the forwarding controls
    always_comb
    begin : operand_proc
        case (forwarda_ex)
            FWD_MEM: src_a_ex = alu_result_mem;
            FWD_WB:  src_a_ex = result_wb;
            default: src_a_ex = rdata1_ex;
        endcase
        case (forwardb_ex)
            FWD_MEM: store_data_ex = alu_result_mem;
            FWD_WB:  store_data_ex = result_wb;
            default: store_data_ex = rdata2_ex;
        endcase
    end

    riscv_core_alu alu_i
    (
        .i_op     (alu_op_ex),
        .i_a      (src_a_ex),
        .i_b      (alu_src_imm_ex ? imm_ex : store_data_ex),
        .o_result (alu_result_ex),
        .o_zero   (alu_zero_ex)
    );

    assign pcsrc_ex = branch_ex && alu_zero_ex;

    riscv_core_data_mem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) data_mem_i (
        .i_clk   (i_clk),
        .i_we    (mem_write_mem),
        .i_addr  (alu_result_mem),
        .i_wdata (store_data_mem),
        .o_rdata (load_data_mem)
    );

    riscv_core_hazard_unit hazard_unit_i
    (
        .i_hazard_unit_rs1_id        (rs1_id),
        .i_hazard_unit_rs2_id        (rs2_id),
        .i_hazard_unit_rs1_ex        (rs1_ex),
        .i_hazard_unit_rs2_ex        (rs2_ex),
        .i_hazard_unit_rd_ex         (rd_ex),
        .i_hazard_unit_rd_mem        (rd_mem),
        .i_hazard_unit_rd_wb         (rd_wb),
        .i_hazard_unit_regwrite_mem  (regwrite_mem),
        .i_hazard_unit_regwrite_wb   (regwrite_wb),
        .i_hazard_unit_resultsrc0_ex (res_src_ex == RES_MEM),
        .i_hazard_unit_pcsrc_ex      (pcsrc_ex),
        .o_hazard_unit_forwarda_ex   (forwarda_ex),
        .o_hazard_unit_forwardb_ex   (forwardb_ex),
        .o_hazard_unit_stall_if      (stall_if),
        .o_hazard_unit_stall_id      (stall_id),
        .o_hazard_unit_flush_id      (flush_id),
        .o_hazard_unit_flush_ex      (flush_ex)
    );

    assign result_wb   = (res_src_wb == RES_MEM) ? load_data_wb : alu_result_wb;
    assign o_imem_addr = pc_q;
    assign o_wb_valid  = regwrite_wb && (rd_wb != '0);
    assign o_wb_rd     = rd_wb;
    assign o_wb_data   = result_wb;

endmodule

//--- hdl/riscv_core_alu.sv
// ALU: 64-bit add, sub, and, or, xor and signed set-less-than with a zero flag
module riscv_core_alu
(
    input  riscv_core_ctrl_pkg::alu_op_e i_op,
    input  riscv_core_isa_pkg::xword_t   i_a,
    input  riscv_core_isa_pkg::xword_t   i_b,
    output riscv_core_isa_pkg::xword_t   o_result,
    output logic                         o_zero
);

    import riscv_core_ctrl_pkg::*;

    always_comb
    begin : alu_proc
        case (i_op)
            ALU_ADD:
            begin
                o_result = i_a + i_b;
            end
            ALU_SUB:
            begin
                o_result = i_a - i_b;
            end
            ALU_AND:
            begin
                o_result = i_a & i_b;
            end
            ALU_OR:
            begin
                o_result = i_a | i_b;
            end
            ALU_XOR:
            begin
                o_result = i_a ^ i_b;
            end
            ALU_SLT:
            begin
                o_result = {63'd0, $signed(i_a) < $signed(i_b)};
            end
            default:
            begin
                o_result = '0;
            end
        endcase
    end

    // beq subtracts, so zero means equal
    assign o_zero = (o_result == '0);

endmodule

//--- hdl/riscv_core_ctrl_pkg.sv
// Core control package: ALU operation, forwarding source and result source encodings
package riscv_core_ctrl_pkg;

    typedef enum logic [2:0]
    {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // EX operand source
    typedef enum logic [1:0]
    {
        FWD_NONE = 2'd0,
        FWD_WB   = 2'd1,
        FWD_MEM  = 2'd2
    } fwd_sel_e;

    // Writeback value comes from the ALU or from a load
    typedef enum logic
    {
        RES_ALU = 1'b0,
        RES_MEM = 1'b1
    } res_src_e;

endpackage

//--- hdl/riscv_core_data_mem.sv
// Data memory: doubleword array with combinational read and write at the clock edge
module riscv_core_data_mem
#(
    parameter int DMEM_WORDS = 256
)
(
    input  logic                       i_clk,
    input  logic                       i_we,
    input  riscv_core_isa_pkg::xword_t i_addr,
    input  riscv_core_isa_pkg::xword_t i_wdata,
    output riscv_core_isa_pkg::xword_t o_rdata
);

    import riscv_core_isa_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    xword_t        mem [DMEM_WORDS];
    logic [AW-1:0] index;

    // Doubleword index, wraps around the depth
    assign index = AW'(i_addr[63:3] % 61'(DMEM_WORDS));

    always_ff @(posedge i_clk)
    begin : write_proc
        if (i_we)
        begin
            mem[index] <= i_wdata;
        end
    end

    assign o_rdata = mem[index];

endmodule

//--- hdl/riscv_core_decoder.sv
// Instruction decoder: control levels and sign-extended immediate for the RV64I subset
module riscv_core_decoder
(
    input  riscv_core_isa_pkg::instr_t   i_instr,
    output riscv_core_isa_pkg::reg_idx_t o_rs1,
    output riscv_core_isa_pkg::reg_idx_t o_rs2,
    output riscv_core_isa_pkg::reg_idx_t o_rd,
    output riscv_core_isa_pkg::xword_t   o_imm,
    output riscv_core_ctrl_pkg::alu_op_e o_alu_op,
    output logic                         o_alu_src_imm,
    output logic                         o_regwrite,
    output logic                         o_mem_read,
    output logic                         o_mem_write,
    output logic                         o_branch
);

    import riscv_core_isa_pkg::*;
    import riscv_core_ctrl_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    xword_t  imm_i;
    xword_t  imm_s;
    xword_t  imm_b;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    assign o_rd   = i_instr[11:7];
    assign o_rs1  = i_instr[19:15];
    assign o_rs2  = i_instr[24:20];

    assign imm_i = {{52{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{52{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{52{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};

    // Anything not matched below stays a bubble
    always_comb
    begin : decode_proc
        o_imm         = '0;
        o_alu_op      = ALU_ADD;
        o_alu_src_imm = 1'b0;
        o_regwrite    = 1'b0;
        o_mem_read    = 1'b0;
        o_mem_write   = 1'b0;
        o_branch      = 1'b0;
        case (opcode)
            OPC_OP:
            begin
                o_regwrite = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD_SUB}: o_alu_op = ALU_ADD;
                    {F7_SUB, F3_ADD_SUB}:  o_alu_op = ALU_SUB;
                    {F7_BASE, F3_AND}:     o_alu_op = ALU_AND;
                    {F7_BASE, F3_OR}:      o_alu_op = ALU_OR;
                    {F7_BASE, F3_XOR}:     o_alu_op = ALU_XOR;
                    {F7_BASE, F3_SLT}:     o_alu_op = ALU_SLT;
                    default:               o_regwrite = 1'b0;
                endcase
            end
            OPC_OP_IMM:
            begin
                o_imm         = imm_i;
                o_alu_src_imm = 1'b1;
                o_regwrite    = (funct3 == F3_ADDI);
            end
            OPC_LOAD:
            begin
                o_imm         = imm_i;
                o_alu_src_imm = 1'b1;
                o_regwrite    = (funct3 == F3_LD);
                o_mem_read    = (funct3 == F3_LD);
            end
            OPC_STORE:
            begin
                o_imm         = imm_s;
                o_alu_src_imm = 1'b1;
                o_mem_write   = (funct3 == F3_SD);
            end
            OPC_BRANCH:
            begin
                // Equality through the ALU zero flag
                o_imm    = imm_b;
                o_alu_op = ALU_SUB;
                o_branch = (funct3 == F3_BEQ);
            end
            default:
            begin
                o_imm = '0;
            end
        endcase
    end

endmodule

//--- hdl/riscv_core_hazard_unit.sv
// Hazard unit: EX operand forwarding, load-use stall and branch flush control
module riscv_core_hazard_unit
(
    // Register indices per stage
    input  riscv_core_isa_pkg::reg_idx_t  i_hazard_unit_rs1_id,
    input  riscv_core_isa_pkg::reg_idx_t  i_hazard_unit_rs2_id,
    input  riscv_core_isa_pkg::reg_idx_t  i_hazard_unit_rs1_ex,
    input  riscv_core_isa_pkg::reg_idx_t  i_hazard_unit_rs2_ex,
    input  riscv_core_isa_pkg::reg_idx_t  i_hazard_unit_rd_ex,
    input  riscv_core_isa_pkg::reg_idx_t  i_hazard_unit_rd_mem,
    input  riscv_core_isa_pkg::reg_idx_t  i_hazard_unit_rd_wb,

    // Control levels from the later stages
    input  logic                          i_hazard_unit_regwrite_mem,
    input  logic                          i_hazard_unit_regwrite_wb,
    input  logic                          i_hazard_unit_resultsrc0_ex,
    input  logic                          i_hazard_unit_pcsrc_ex,

    // Forwarding selects
    output riscv_core_ctrl_pkg::fwd_sel_e o_hazard_unit_forwarda_ex,
    output riscv_core_ctrl_pkg::fwd_sel_e o_hazard_unit_forwardb_ex,

    // Stalls and flushes
    output logic                          o_hazard_unit_stall_if,
    output logic                          o_hazard_unit_stall_id,
    output logic                          o_hazard_unit_flush_id,
    output logic                          o_hazard_unit_flush_ex
);

    import riscv_core_isa_pkg::*;
    import riscv_core_ctrl_pkg::*;

    logic lwstall_detection;

    // MEM is younger than WB so it wins; x0 is never forwarded
    function automatic fwd_sel_e fwd_select(input reg_idx_t rs);
        fwd_sel_e sel;
        if ((rs != '0) && i_hazard_unit_regwrite_mem && (rs == i_hazard_unit_rd_mem))
        begin
            sel = FWD_MEM;
        end
        else if ((rs != '0) && i_hazard_unit_regwrite_wb && (rs == i_hazard_unit_rd_wb))
        begin
            sel = FWD_WB;
        end
        else
        begin
            sel = FWD_NONE;
        end
        return sel;
    endfunction

    always_comb
    begin : forwarding_proc
        o_hazard_unit_forwarda_ex = fwd_select(i_hazard_unit_rs1_ex);
        o_hazard_unit_forwardb_ex = fwd_select(i_hazard_unit_rs2_ex);
    end

    // Load in EX feeding the instruction in decode
    // rs2 is compared even when the decoding instruction has no rs2
    always_comb
    begin : stall_proc
        lwstall_detection = i_hazard_unit_resultsrc0_ex &&
                            ((i_hazard_unit_rs1_id == i_hazard_unit_rd_ex) ||
                             (i_hazard_unit_rs2_id == i_hazard_unit_rd_ex));
        o_hazard_unit_stall_if = lwstall_detection;
        o_hazard_unit_stall_id = lwstall_detection;
    end

    // Taken branch kills the two younger instructions
    always_comb
    begin : flush_proc
        o_hazard_unit_flush_id = i_hazard_unit_pcsrc_ex;
        o_hazard_unit_flush_ex = lwstall_detection || i_hazard_unit_pcsrc_ex;
    end

endmodule

//--- hdl/riscv_core_isa_pkg.sv
// RV64I subset ISA package: register, word and instruction types with opcode and funct values
package riscv_core_isa_pkg;

    typedef logic [4:0]  reg_idx_t;
    typedef logic [63:0] xword_t;
    typedef logic [31:0] instr_t;

    // Instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // Major opcodes
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // Register and immediate ALU ops
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_ADDI    = 3'b000;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // Doubleword access and branch
    localparam funct3_t F3_LD  = 3'b011;
    localparam funct3_t F3_SD  = 3'b011;
    localparam funct3_t F3_BEQ = 3'b000;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_SUB  = 7'b0100000;

endpackage

//--- hdl/riscv_core_regfile.sv
// Register file: x1..x31 with two combinational read ports and write-through from the write port
module riscv_core_regfile
(
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  riscv_core_isa_pkg::reg_idx_t i_rs1,
    input  riscv_core_isa_pkg::reg_idx_t i_rs2,
    input  riscv_core_isa_pkg::reg_idx_t i_rd,
    input  logic                         i_we,
    input  riscv_core_isa_pkg::xword_t   i_wdata,
    output riscv_core_isa_pkg::xword_t   o_rdata1,
    output riscv_core_isa_pkg::xword_t   o_rdata2
);

    import riscv_core_isa_pkg::*;

    xword_t regs [1:31];

    // x0 is hardwired; a write in flight is seen by decode
    function automatic xword_t read_port(input reg_idx_t idx);
        xword_t value;
        if (idx == '0)
        begin
            value = '0;
        end
        else if (i_we && (idx == i_rd))
        begin
            value = i_wdata;
        end
        else
        begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin : write_proc
        if (!i_rst_n)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_we && (i_rd != '0))
        begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rdata1 = read_port(i_rs1);
    assign o_rdata2 = read_port(i_rs2);

endmodule

//--- riscv_core.f
hdl/riscv_core_isa_pkg.sv
hdl/riscv_core_ctrl_pkg.sv
hdl/riscv_core_hazard_unit.sv
hdl/riscv_core_decoder.sv
hdl/riscv_core_regfile.sv
hdl/riscv_core_alu.sv
hdl/riscv_core_data_mem.sv
hdl/riscv_core.sv
bench/riscv_core_tb.sv
